// File: hw/issue_config.svh
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// Datapath word
`define ISSUE_DATA_W 16

// ROB entry tag, sized for an eight-entry ROB
`define ISSUE_TAG_W 3

// Architectural register index
`define ISSUE_REG_W 3

`define ISSUE_NUM_ALU_RS 3 // ALU reservation stations

// JSR and JSRR write the return PC here
`define ISSUE_LINK_REG 7

`endif

// File: hw/issue_pkg.sv
`include "issue_config.svh"

package issue_pkg;

	typedef logic [`ISSUE_DATA_W-1:0] word_t;
	typedef logic [`ISSUE_TAG_W-1:0] tag_t;
	typedef logic [`ISSUE_REG_W-1:0] reg_idx_t;
	typedef logic [1:0] rs_id_t; // ALU station number

	// LC-3b opcode field, instr[15:12]
	typedef enum logic [3:0] {
		op_br   = 4'h0,
		op_add  = 4'h1,
		op_ldb  = 4'h2,
		op_stb  = 4'h3,
		op_jsr  = 4'h4,
		op_and  = 4'h5,
		op_ldr  = 4'h6,
		op_str  = 4'h7,
		op_rti  = 4'h8,
		op_not  = 4'h9,
		op_ldi  = 4'ha,
		op_sti  = 4'hb,
		op_jmp  = 4'hc,
		op_shf  = 4'hd,
		op_lea  = 4'he,
		op_trap = 4'hf
	} opcode_t;

	// Where an instruction goes at issue
	typedef enum logic [2:0] {
		class_alu,
		class_load,
		class_store,
		class_br,
		class_lea,
		class_jmp,
		class_jsr,
		class_none
	} op_class_t;

endpackage

// File: hw/instr_decode.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module instr_decode import issue_pkg::*;
(
	input  word_t     instr,
	output opcode_t   opcode,
	output op_class_t op_class,
	output reg_idx_t  dest_reg,
	output reg_idx_t  sr1_idx,
	output reg_idx_t  sr2_idx,
	output word_t     imm5,
	output word_t     off6_byte,
	output word_t     off6_word,
	output word_t     off9,
	output word_t     off11,
	output logic      use_imm,
	output logic      jsr_rel
);

assign opcode   = opcode_t'(instr[15:12]);
assign dest_reg = instr[11:9]; // Also the store source
assign sr1_idx  = instr[8:6];
assign sr2_idx  = instr[2:0];
assign jsr_rel  = instr[11]; // JSR when set, JSRR when clear

// Sign extension
assign imm5      = {{(`ISSUE_DATA_W-5){instr[4]}}, instr[4:0]};
assign off6_byte = {{(`ISSUE_DATA_W-6){instr[5]}}, instr[5:0]};

// Word offsets, scaled to bytes
assign off6_word = {{(`ISSUE_DATA_W-7){instr[5]}}, instr[5:0], 1'b0};
assign off9      = {{(`ISSUE_DATA_W-10){instr[8]}}, instr[8:0], 1'b0};
assign off11     = {{(`ISSUE_DATA_W-12){instr[10]}}, instr[10:0], 1'b0};

// SHF always takes its amount from the instruction
assign use_imm = instr[5] || (opcode == op_shf);

always_comb
begin
	case (opcode)
		op_add, op_and, op_not, op_shf: op_class = class_alu;
		op_ldr, op_ldb:                 op_class = class_load;
		op_str, op_stb:                 op_class = class_store;
		op_br:                          op_class = class_br;
		op_lea:                         op_class = class_lea;
		op_jmp:                         op_class = class_jmp;
		op_jsr:                         op_class = class_jsr;
		default:                        op_class = class_none; // LDI, STI, TRAP, RTI
	endcase
end

endmodule

// File: hw/operand_select.sv
`timescale 1ns/1ps

module operand_select import issue_pkg::*;
(
	input  logic  reg_busy,
	input  word_t reg_data,
	input  tag_t  reg_tag,
	input  logic  cdb_valid,
	input  tag_t  cdb_tag,
	input  word_t cdb_data,
	input  logic  rob_valid,
	input  word_t rob_value,
	output word_t value,
	output logic  valid,
	output tag_t  wait_tag
);

// Register file first, then the CDB broadcast, then the ROB
always_comb
begin
	value    = '0;
	valid    = 1'b1;
	wait_tag = '0;
	if (!reg_busy)
	begin
		value = reg_data;
	end
	else if (cdb_valid && (cdb_tag == reg_tag))
	begin
		value = cdb_data; // Producer completing this cycle
	end
	else if (rob_valid)
	begin
		value = rob_value;
	end
	else
	begin
		// Station waits on the producer's tag
		valid    = 1'b0;
		wait_tag = reg_tag;
	end
end

endmodule

// File: hw/branch_ctrl.sv
`timescale 1ns/1ps

module branch_ctrl import issue_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      flush,
	input  op_class_t op_class,
	input  word_t     curr_pc,
	input  word_t     off9,
	input  word_t     off11,
	input  logic      jsr_rel,
	input  word_t     base_value,
	input  logic      predict_taken,
	input  logic      issue,
	output logic      redirect,
	output word_t     redirect_pc,
	output logic      bubble
);

logic is_jump;

assign is_jump = (op_class == class_jmp) || (op_class == class_jsr);

// Target is also the BR fall-back value when not predicted taken
always_comb
begin
	case (op_class)
		class_br:
			redirect_pc = curr_pc + off9;
		class_jsr:
			redirect_pc = jsr_rel ? (curr_pc + off11) : base_value;
		class_jmp:
			redirect_pc = base_value; // Includes RET
		default:
			redirect_pc = '0;
	endcase
end

assign redirect = issue && (is_jump || ((op_class == class_br) && predict_taken));

// Fetch still presents the old fall-through word for one cycle
always_ff @(posedge clk)
begin
	if (!rst_n || flush)
	begin
		bubble <= 1'b0;
	end
	else
	begin
		bubble <= redirect;
	end
end

endmodule

// File: hw/dispatch_ctrl.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module dispatch_ctrl import issue_pkg::*;
(
	input  opcode_t   opcode,
	input  op_class_t op_class,
	input  reg_idx_t  dest_reg,
	input  word_t     imm5,
	input  word_t     off6_byte,
	input  word_t     off6_word,
	input  word_t     off9,
	input  logic      use_imm,
	input  logic      jsr_rel,
	input  word_t     j_value,
	input  logic      j_valid,
	input  tag_t      j_tag,
	input  word_t     k_value,
	input  logic      k_valid,
	input  tag_t      k_tag,
	input  word_t     s_value,
	input  logic      s_valid,
	input  tag_t      s_tag,
	input  logic [`ISSUE_NUM_ALU_RS-1:0] rs_busy,
	input  logic      lsb_full,
	input  logic      rob_full,
	input  tag_t      rob_tail,
	input  word_t     curr_pc,
	input  logic      instr_is_new,
	input  logic      bubble,
	input  word_t     redirect_pc,
	input  logic      predict_taken,
	output logic      stall,
	output logic      issue,
	output logic      rs_write,
	output rs_id_t    rs_id,
	output opcode_t   rs_op,
	output word_t     rs_vj,
	output logic      rs_vj_valid,
	output tag_t      rs_qj,
	output word_t     rs_vk,
	output logic      rs_vk_valid,
	output tag_t      rs_qk,
	output logic      lsb_write,
	output opcode_t   lsb_op,
	output word_t     lsb_offset,
	output word_t     lsb_vbase,
	output logic      lsb_vbase_valid,
	output tag_t      lsb_qbase,
	output word_t     lsb_vsrc,
	output logic      lsb_vsrc_valid,
	output tag_t      lsb_qsrc,
	output tag_t      lsb_dest,
	output logic      rob_write,
	output opcode_t   rob_op,
	output reg_idx_t  rob_dest_reg,
	output word_t     rob_value,
	output word_t     rob_pc,
	output logic      reg_set_busy,
	output reg_idx_t  reg_dest,
	output tag_t      reg_tag
);

logic is_alu;
logic is_load;
logic is_mem;
logic is_jsr;
logic present;
logic res_stall;

assign is_alu  = (op_class == class_alu);
assign is_load = (op_class == class_load);
assign is_mem  = is_load || (op_class == class_store);
assign is_jsr  = (op_class == class_jsr);
assign present = instr_is_new && !bubble; // Bubble cycle word is discarded

// Indirect jumps need their target now
assign res_stall = rob_full
	|| (is_alu && (&rs_busy))
	|| (is_mem && lsb_full)
	|| (((op_class == class_jmp) || (is_jsr && !jsr_rel)) && !j_valid);

assign stall = present && res_stall;
assign issue = present && !res_stall && (op_class != class_none);

// Lowest free station wins
always_comb
begin
	rs_id = '0;
	for (int i = `ISSUE_NUM_ALU_RS - 1; i >= 0; i--)
	begin
		if (!rs_busy[i])
			rs_id = rs_id_t'(i);
	end
end

assign rs_write    = issue && is_alu;
assign rs_op       = opcode;
assign rs_vj       = j_value;
assign rs_vj_valid = j_valid;
assign rs_qj       = j_tag;
assign rs_vk       = use_imm ? imm5 : k_value;
assign rs_vk_valid = use_imm || k_valid;
assign rs_qk       = use_imm ? '0 : k_tag;

assign lsb_write       = issue && is_mem;
assign lsb_op          = opcode;
assign lsb_offset      = ((opcode == op_ldb) || (opcode == op_stb)) ? off6_byte : off6_word;
assign lsb_vbase       = j_value;
assign lsb_vbase_valid = j_valid;
assign lsb_qbase       = j_tag;
assign lsb_vsrc        = s_value;
assign lsb_vsrc_valid  = s_valid;
assign lsb_qsrc        = s_tag;
assign lsb_dest        = is_load ? rob_tail : '0; // Stores return nothing on the CDB

// JMP writes no register, so it takes no ROB slot
assign rob_write = issue && (op_class != class_jmp);
assign rob_op    = opcode;
assign rob_pc    = curr_pc;

always_comb
begin
	rob_value    = '0;
	rob_dest_reg = dest_reg;
	case (op_class)
		class_lea:
			rob_value = curr_pc + off9;
		class_jsr:
		begin
			rob_value    = curr_pc; // Return address
			rob_dest_reg = reg_idx_t'(`ISSUE_LINK_REG);
		end
		class_br:
			rob_value = predict_taken ? curr_pc : redirect_pc; // Recovery PC on mispredict
		class_store:
			rob_dest_reg = '0;
		default:;
	endcase
end

assign reg_set_busy = issue && (is_alu || is_load || is_jsr || (op_class == class_lea));
assign reg_dest     = is_jsr ? reg_idx_t'(`ISSUE_LINK_REG) : dest_reg;
assign reg_tag      = rob_tail;

endmodule

// File: hw/issue_control.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_control import issue_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      flush,
	// Fetch
	input  word_t     instr,
	input  logic      instr_is_new,
	input  word_t     curr_pc,
	// CDB
	input  logic      cdb_valid,
	input  tag_t      cdb_tag,
	input  word_t     cdb_data,
	// Structural state
	input  logic [`ISSUE_NUM_ALU_RS-1:0] rs_busy,
	input  logic      lsb_full,
	input  logic      rob_full,
	// ROB allocation and read ports
	input  tag_t      rob_tail,
	input  word_t     rob_src1_value,
	input  logic      rob_src1_valid,
	input  word_t     rob_src2_value,
	input  logic      rob_src2_valid,
	// Register file reads
	input  logic      sr1_busy,
	input  word_t     sr1_data,
	input  tag_t      sr1_tag,
	input  logic      sr2_busy,
	input  word_t     sr2_data,
	input  tag_t      sr2_tag,
	input  logic      src_busy,
	input  word_t     src_data,
	input  tag_t      src_tag,
	input  logic      predict_taken,
	// Register file
	output reg_idx_t  sr1_idx,
	output reg_idx_t  sr2_idx,
	output reg_idx_t  src_idx,
	output logic      reg_set_busy,
	output reg_idx_t  reg_dest,
	output tag_t      reg_tag,
	// ROB
	output tag_t      rob_rd1_addr,
	output tag_t      rob_rd2_addr,
	output logic      rob_write,
	output opcode_t   rob_op,
	output reg_idx_t  rob_dest_reg,
	output word_t     rob_value,
	output word_t     rob_pc,
	// ALU stations
	output logic      rs_write,
	output rs_id_t    rs_id,
	output opcode_t   rs_op,
	output word_t     rs_vj,
	output logic      rs_vj_valid,
	output tag_t      rs_qj,
	output word_t     rs_vk,
	output logic      rs_vk_valid,
	output tag_t      rs_qk,
	// Load/store buffer
	output logic      lsb_write,
	output opcode_t   lsb_op,
	output word_t     lsb_offset,
	output word_t     lsb_vbase,
	output logic      lsb_vbase_valid,
	output tag_t      lsb_qbase,
	output word_t     lsb_vsrc,
	output logic      lsb_vsrc_valid,
	output tag_t      lsb_qsrc,
	output tag_t      lsb_dest,
	// Fetch
	output logic      stall,
	output logic      redirect,
	output word_t     redirect_pc
);

opcode_t   opcode;
op_class_t op_class;
reg_idx_t  dest_reg;
word_t     imm5;
word_t     off6_byte;
word_t     off6_word;
word_t     off9;
word_t     off11;
logic      use_imm;
logic      jsr_rel;
word_t     j_value;
logic      j_valid;
tag_t      j_tag;
word_t     k_value;
logic      k_valid;
tag_t      k_tag;
word_t     s_value;
logic      s_valid;
tag_t      s_tag;
logic      issue;
logic      bubble;

assign src_idx      = dest_reg; // Store data register sits in the DR field
assign rob_rd1_addr = sr1_tag;
// Port 2 serves SR2 or, for stores, the data register
assign rob_rd2_addr = (op_class == class_store) ? src_tag : sr2_tag;

instr_decode u_decode (.*);

// Base or J operand
operand_select u_sel_j (
	.reg_busy (sr1_busy),
	.reg_data (sr1_data),
	.reg_tag  (sr1_tag),
	.cdb_valid(cdb_valid),
	.cdb_tag  (cdb_tag),
	.cdb_data (cdb_data),
	.rob_valid(rob_src1_valid),
	.rob_value(rob_src1_value),
	.value    (j_value),
	.valid    (j_valid),
	.wait_tag (j_tag)
);

operand_select u_sel_k (
	.reg_busy (sr2_busy),
	.reg_data (sr2_data),
	.reg_tag  (sr2_tag),
	.cdb_valid(cdb_valid),
	.cdb_tag  (cdb_tag),
	.cdb_data (cdb_data),
	.rob_valid(rob_src2_valid),
	.rob_value(rob_src2_value),
	.value    (k_value),
	.valid    (k_valid),
	.wait_tag (k_tag)
);

// Store data
operand_select u_sel_s (
	.reg_busy (src_busy),
	.reg_data (src_data),
	.reg_tag  (src_tag),
	.cdb_valid(cdb_valid),
	.cdb_tag  (cdb_tag),
	.cdb_data (cdb_data),
	.rob_valid(rob_src2_valid),
	.rob_value(rob_src2_value),
	.value    (s_value),
	.valid    (s_valid),
	.wait_tag (s_tag)
);

branch_ctrl u_branch (
	.base_value(j_value),
	.*
);

dispatch_ctrl u_dispatch (.*);

endmodule

// File: verif/issue_control_assertions.sv
`timescale 1ns/1ps

module issue_control_assertions
(
	input logic clk,
	input logic rst_n,
	input logic flush,
	input logic stall,
	input logic redirect,
	input logic rs_write,
	input logic lsb_write,
	input logic rob_write,
	input logic reg_set_busy
);

logic any_write;

assign any_write = rs_write || lsb_write || rob_write || reg_set_busy;

// Back-pressure and dispatch are exclusive
a_stall_no_write: assert property (@(posedge clk) disable iff (!rst_n) !(stall && any_write))
	else $error("stall raised together with a write strobe");

a_quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !(any_write || stall || redirect))
	else $error("strobe high in the first cycle after reset");

// Fall-through word behind a redirect is dropped unless a flush cleared the bubble
a_bubble_drop: assert property (@(posedge clk) disable iff (!rst_n) (redirect && !flush) |=> !any_write)
	else $error("write strobe high in the cycle after a redirect");

endmodule

bind issue_control issue_control_assertions u_assertions (
	.clk         (clk),
	.rst_n       (rst_n),
	.flush       (flush),
	.stall       (stall),
	.redirect    (redirect),
	.rs_write    (rs_write),
	.lsb_write   (lsb_write),
	.rob_write   (rob_write),
	.reg_set_busy(reg_set_busy)
);

// File: verif/issue_control_tb.sv
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_control_tb import issue_pkg::*;;

localparam int RAND_CYCLES = 2000;
localparam int DIR_CYCLES  = 200;
localparam int MAX_CYCLES  = RAND_CYCLES + DIR_CYCLES + 100;

logic clk = 1'b0;
logic rst_n;
logic flush;
word_t instr;
logic instr_is_new;
word_t curr_pc;
logic cdb_valid;
tag_t cdb_tag;
word_t cdb_data;
logic [`ISSUE_NUM_ALU_RS-1:0] rs_busy;
logic lsb_full;
logic rob_full;
tag_t rob_tail;
word_t rob_src1_value;
logic rob_src1_valid;
word_t rob_src2_value;
logic rob_src2_valid;
logic sr1_busy;
word_t sr1_data;
tag_t sr1_tag;
logic sr2_busy;
word_t sr2_data;
tag_t sr2_tag;
logic src_busy;
word_t src_data;
tag_t src_tag;
logic predict_taken;
reg_idx_t sr1_idx;
reg_idx_t sr2_idx;
reg_idx_t src_idx;
logic reg_set_busy;
reg_idx_t reg_dest;
tag_t reg_tag;
tag_t rob_rd1_addr;
tag_t rob_rd2_addr;
logic rob_write;
opcode_t rob_op;
reg_idx_t rob_dest_reg;
word_t rob_value;
word_t rob_pc;
logic rs_write;
rs_id_t rs_id;
opcode_t rs_op;
word_t rs_vj;
logic rs_vj_valid;
tag_t rs_qj;
word_t rs_vk;
logic rs_vk_valid;
tag_t rs_qk;
logic lsb_write;
opcode_t lsb_op;
word_t lsb_offset;
word_t lsb_vbase;
logic lsb_vbase_valid;
tag_t lsb_qbase;
word_t lsb_vsrc;
logic lsb_vsrc_valid;
tag_t lsb_qsrc;
tag_t lsb_dest;
logic stall;
logic redirect;
word_t redirect_pc;

integer seed = 32'hceb7_c132;
int cycles = 0;
int word_errs = 0;
int tag_errs = 0;
int bit_errs = 0;
int op_errs = 0;
string test_name = "reset";
logic model_bubble = 1'b0;
logic e_redirect = 1'b0;

// Mostly kept classes with LDI and TRAP standing in for unsupported opcodes
opcode_t op_mix [16] = '{op_add, op_and, op_not, op_shf, op_ldr, op_ldb, op_str, op_stb,
	op_br, op_br, op_lea, op_jmp, op_jsr, op_jsr, op_ldi, op_trap};
opcode_t dir_mix [8] = '{op_br, op_br, op_jmp, op_jsr, op_jsr, op_add, op_ldr, op_str};

issue_control uut (.*);

always #50 clk = ~clk;

always @(posedge clk)
begin
	cycles <= cycles + 1;
	if (cycles >= MAX_CYCLES)
	begin
		$display("Timeout: stimulus did not complete within %0d cycles", MAX_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end
end

task automatic check_word(input string sig, input word_t exp, input word_t act);
	if (exp !== act)
	begin
		word_errs++;
		$display("MISMATCH %s %s expected %h actual %h", test_name, sig, exp, act);
	end
endtask

task automatic check_tag(input string sig, input tag_t exp, input tag_t act);
	if (exp !== act)
	begin
		tag_errs++;
		$display("MISMATCH %s %s expected %h actual %h", test_name, sig, exp, act);
	end
endtask

task automatic check_bit(input string sig, input logic exp, input logic act);
	if (exp !== act)
	begin
		bit_errs++;
		$display("MISMATCH %s %s expected %b actual %b", test_name, sig, exp, act);
	end
endtask

task automatic check_op(input string sig, input opcode_t exp, input opcode_t act);
	if (exp !== act)
	begin
		op_errs++;
		$display("MISMATCH %s %s expected %s actual %s", test_name, sig, exp.name(), act.name());
	end
endtask

function automatic op_class_t class_of(input opcode_t op);
	case (op)
		op_add, op_and, op_not, op_shf: return class_alu;
		op_ldr, op_ldb: return class_load;
		op_str, op_stb: return class_store;
		op_br: return class_br;
		op_lea: return class_lea;
		op_jmp: return class_jmp;
		op_jsr: return class_jsr;
		default: return class_none;
	endcase
endfunction

// Register file, then CDB, then ROB, else wait on the tag
task automatic resolve(input logic busy, input word_t data, input tag_t tag, input logic rv,
	input word_t rval, output word_t v, output logic ok, output tag_t q);
	ok = 1'b1;
	q  = '0;
	v  = '0;
	if (!busy)
		v = data;
	else if (cdb_valid && (cdb_tag == tag))
		v = cdb_data;
	else if (rv)
		v = rval;
	else
	begin
		ok = 1'b0;
		q  = tag;
	end
endtask

task automatic init_inputs();
	flush = 1'b0;
	instr = '0;
	instr_is_new = 1'b0;
	curr_pc = '0;
	cdb_valid = 1'b0;
	cdb_tag = '0;
	cdb_data = '0;
	rs_busy = '0;
	lsb_full = 1'b0;
	rob_full = 1'b0;
	rob_tail = '0;
	rob_src1_value = '0;
	rob_src1_valid = 1'b0;
	rob_src2_value = '0;
	rob_src2_valid = 1'b0;
	sr1_busy = 1'b0;
	sr1_data = '0;
	sr1_tag = '0;
	sr2_busy = 1'b0;
	sr2_data = '0;
	sr2_tag = '0;
	src_busy = 1'b0;
	src_data = '0;
	src_tag = '0;
	predict_taken = 1'b0;
endtask

// Directed mode keeps resources free and favours redirects and flushes
task automatic drive_inputs(input logic directed);
	logic [31:0] r;
	opcode_t op;
	r = $random(seed);
	op = directed ? dir_mix[r[2:0]] : op_mix[r[3:0]];
	instr = {op, r[15:4]};
	instr_is_new = directed || (r[18:16] != 3'd0);
	predict_taken = directed ? (r[19] || r[20]) : r[19];
	flush = directed ? (r[22:21] == 2'd0) : (r[26:21] == 6'd0);
	rob_full = !directed && (r[29:27] == 3'd0);
	lsb_full = !directed && (r[31:30] == 2'd0);
	r = $random(seed);
	rs_busy = r[`ISSUE_NUM_ALU_RS-1:0];
	rob_tail = r[5:3];
	cdb_valid = r[6];
	cdb_tag = r[9:7];
	sr1_busy = r[10];
	sr1_tag = r[13:11];
	sr2_busy = r[14];
	sr2_tag = r[17:15];
	src_busy = r[18];
	src_tag = r[21:19];
	rob_src1_valid = r[22];
	rob_src2_valid = r[23];
	r = $random(seed);
	curr_pc = r[15:0];
	cdb_data = r[31:16];
	r = $random(seed);
	sr1_data = r[15:0];
	sr2_data = r[31:16];
	r = $random(seed);
	src_data = r[15:0];
	rob_src1_value = r[31:16];
	r = $random(seed);
	rob_src2_value = r[15:0];
endtask

task automatic predict_and_check();
	opcode_t op;
	op_class_t cls;
	reg_idx_t dr;
	rs_id_t e_id;
	word_t jv, kv, sv, imm5, off6b, off6w, off9, off11, target, e_vk;
	logic jok, kok, sok, present, rstall, issue, use_imm, e_vk_ok, is_mem, e_busy;
	tag_t jq, kq, sq;
	op = opcode_t'(instr[15:12]);
	cls = class_of(op);
	dr = instr[11:9];
	resolve(sr1_busy, sr1_data, sr1_tag, rob_src1_valid, rob_src1_value, jv, jok, jq);
	resolve(sr2_busy, sr2_data, sr2_tag, rob_src2_valid, rob_src2_value, kv, kok, kq);
	resolve(src_busy, src_data, src_tag, rob_src2_valid, rob_src2_value, sv, sok, sq);
	imm5 = word_t'($signed(instr[4:0]));
	off6b = word_t'($signed(instr[5:0]));
	off6w = word_t'($signed(instr[5:0])) << 1;
	off9 = word_t'($signed(instr[8:0])) << 1;
	off11 = word_t'($signed(instr[10:0])) << 1;
	is_mem = (cls == class_load) || (cls == class_store);
	present = instr_is_new && !model_bubble;
	rstall = rob_full || ((cls == class_alu) && (&rs_busy)) || (is_mem && lsb_full)
		|| (((cls == class_jmp) || ((cls == class_jsr) && !instr[11])) && !jok);
	issue = present && !rstall && (cls != class_none);
	use_imm = instr[5] || (op == op_shf);
	e_vk = use_imm ? imm5 : kv;
	e_vk_ok = use_imm || kok;
	e_busy = issue && ((cls == class_alu) || (cls == class_load) || (cls == class_lea)
		|| (cls == class_jsr));
	if (!rs_busy[0])
		e_id = 2'd0;
	else if (!rs_busy[1])
		e_id = 2'd1;
	else
		e_id = 2'd2;
	case (cls)
		class_br: target = curr_pc + off9;
		class_jsr: target = instr[11] ? (curr_pc + off11) : jv;
		class_jmp: target = jv;
		default: target = '0;
	endcase
	e_redirect = issue && ((cls == class_jmp) || (cls == class_jsr)
		|| ((cls == class_br) && predict_taken));

	check_bit("stall", present && rstall, stall);
	check_bit("rs_write", issue && (cls == class_alu), rs_write);
	check_bit("lsb_write", issue && is_mem, lsb_write);
	check_bit("rob_write", issue && (cls != class_jmp), rob_write);
	check_bit("reg_set_busy", e_busy, reg_set_busy);
	check_bit("redirect", e_redirect, redirect);
	check_tag("sr1_idx", instr[8:6], sr1_idx);
	check_tag("sr2_idx", instr[2:0], sr2_idx);
	check_tag("src_idx", dr, src_idx);
	check_tag("rob_rd1_addr", sr1_tag, rob_rd1_addr);
	check_tag("rob_rd2_addr", (cls == class_store) ? src_tag : sr2_tag, rob_rd2_addr);
	if (issue && (cls == class_alu))
	begin
		check_tag("rs_id", tag_t'(e_id), tag_t'(rs_id));
		check_op("rs_op", op, rs_op);
		check_bit("rs_vj_valid", jok, rs_vj_valid);
		check_bit("rs_vk_valid", e_vk_ok, rs_vk_valid);
		if (jok)
			check_word("rs_vj", jv, rs_vj);
		else
			check_tag("rs_qj", jq, rs_qj);
		if (e_vk_ok)
			check_word("rs_vk", e_vk, rs_vk);
		else
			check_tag("rs_qk", kq, rs_qk);
	end
	if (issue && is_mem)
	begin
		check_op("lsb_op", op, lsb_op);
		check_word("lsb_offset", ((op == op_ldb) || (op == op_stb)) ? off6b : off6w,
			lsb_offset);
		check_bit("lsb_vbase_valid", jok, lsb_vbase_valid);
		if (jok)
			check_word("lsb_vbase", jv, lsb_vbase);
		else
			check_tag("lsb_qbase", jq, lsb_qbase);
		if (cls == class_store)
		begin
			check_bit("lsb_vsrc_valid", sok, lsb_vsrc_valid);
			if (sok)
				check_word("lsb_vsrc", sv, lsb_vsrc);
			else
				check_tag("lsb_qsrc", sq, lsb_qsrc);
		end
		check_tag("lsb_dest", (cls == class_load) ? rob_tail : tag_t'(0), lsb_dest);
	end
	if (issue && (cls != class_jmp))
	begin
		check_op("rob_op", op, rob_op);
		check_word("rob_pc", curr_pc, rob_pc);
		if (cls == class_jsr)
			check_tag("rob_dest_reg", reg_idx_t'(`ISSUE_LINK_REG), rob_dest_reg);
		else if (cls == class_store)
			check_tag("rob_dest_reg", 3'd0, rob_dest_reg);
		else
			check_tag("rob_dest_reg", dr, rob_dest_reg);
		if (cls == class_lea)
			check_word("rob_value", curr_pc + off9, rob_value);
		else if ((cls == class_jsr) || ((cls == class_br) && predict_taken))
			check_word("rob_value", curr_pc, rob_value);
		else if (cls == class_br)
			check_word("rob_value", target, rob_value); // Recovery target
	end
	if (e_busy)
	begin
		check_tag("reg_dest", (cls == class_jsr) ? reg_idx_t'(`ISSUE_LINK_REG) : dr, reg_dest);
		check_tag("reg_tag", rob_tail, reg_tag);
	end
	if (e_redirect)
		check_word("redirect_pc", target, redirect_pc);
endtask

// Model bubble updates at the edge and outputs are checked mid-cycle
task automatic run_cycle(input logic directed);
	@(posedge clk);
	model_bubble = (!rst_n || flush) ? 1'b0 : e_redirect;
	#1;
	drive_inputs(directed);
	@(negedge clk);
	predict_and_check();
endtask

initial
begin
	int total;
	init_inputs();
	rst_n = 1'b0;
	repeat (8) @(posedge clk);
	#1 rst_n = 1'b1;
	test_name = "random";
	for (int i = 0; i < RAND_CYCLES; i++)
		run_cycle(1'b0);
	test_name = "directed_redirect";
	for (int i = 0; i < DIR_CYCLES; i++)
		run_cycle(1'b1);
	total = word_errs + tag_errs + bit_errs + op_errs;
	$display("Error counts: word %0d, tag %0d, bit %0d, opcode %0d",
		word_errs, tag_errs, bit_errs, op_errs);
	if (total == 0)
		$display("NO ERRORS");
	else
		$display("ERRORS FOUND");
	$finish;
end

endmodule

// File: tb.f
+incdir+hw
hw/issue_pkg.sv
hw/instr_decode.sv
hw/operand_select.sv
hw/branch_ctrl.sv
hw/dispatch_ctrl.sv
hw/issue_control.sv
verif/issue_control_assertions.sv
verif/issue_control_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f tb.f --top-module issue_control_tb -o issue_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/issue_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
	exit 0
fi
echo "Pass message not found"
exit 1
